// File: common/core_params_pkg.sv
package core_params_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Core sizing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Entries in the load buffer
    localparam int LD_DEPTH = 4;

    // One bit per branch that is still unresolved
    localparam int BR_WIDTH = 4;

    // Cycles from start_load to the response pulse
    localparam int MEM_LATENCY = 3;

    // 64-bit blocks held by the data memory
    localparam int MEM_BLOCKS = 32;

    // Physical register tag width
    localparam int TAG_WIDTH = 6;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Branch resolution
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [BR_WIDTH-1:0] br_mask_t;

    // SQUASH kills every dependent instruction, CLEAR only drops the branch bit
    typedef enum logic [1:0] {
        NONE   = 2'd0,
        SQUASH = 2'd1,
        CLEAR  = 2'd2
    } br_task_t;

endpackage

// File: common/load_types_pkg.sv
package load_types_pkg;

    import core_params_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memory view
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [15:0] addr_t;
    typedef logic [63:0] data_t;

    // One memory block seen at every access size
    typedef union packed {
        logic [7:0][7:0]  byte_level;
        logic [3:0][15:0] half_level;
        logic [1:0][31:0] word_level;
        logic [63:0]      dbbl_level;
    } mem_block_t;

    // Low two bits of funct3 select the access size
    typedef enum logic [1:0] {
        BYTE   = 2'd0,
        HALF   = 2'd1,
        WORD   = 2'd2,
        DOUBLE = 2'd3
    } mem_size_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Load buffer packets
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        READY_TO_ISSUE   = 2'd0,
        WAITING_FOR_DATA = 2'd1,
        DATA_READY       = 2'd2
    } ld_state_t;

    // What the scheduler hands over for one load
    typedef struct packed {
        addr_t                 base;
        logic signed [11:0]    offset;
        logic [2:0]            funct3;
        logic [TAG_WIDTH-1:0]  dest_tag;
        br_mask_t              b_mask;
    } issue_packet_t;

    // One buffer entry, and also what goes out on the common data bus
    typedef struct packed {
        logic [TAG_WIDTH-1:0]  dest_tag;
        br_mask_t              b_mask;
        logic [2:0]            funct3;
        addr_t                 target_addr;
        data_t                 result;
        ld_state_t             state;
    } fu_packet_t;

endpackage

// File: verilog/priority_select.sv
`timescale 1ns/1ps

module priority_select #(
    parameter int WIDTH = 4
) (
    input  logic [WIDTH-1:0] req,
    output logic [WIDTH-1:0] gnt
);

    // Walk up from bit 0 and keep only the first request seen
    always_comb begin
        logic found;
        found = 1'b0;
        gnt = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (req[i] && !found) begin
                gnt[i] = 1'b1;
                found = 1'b1;
            end
        end
    end

endmodule

// File: load_fu/load_align.sv
`timescale 1ns/1ps

module load_align (
    input  logic [2:0]                funct3,
    input  logic [2:0]                byte_offset,
    input  load_types_pkg::mem_block_t block,
    output load_types_pkg::data_t      result
);

    import load_types_pkg::*;

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    logic [31:0] sel_word;
    logic        sign_ext;

    // The wider sizes ignore the low offset bits
    assign sel_byte = block.byte_level[byte_offset];
    assign sel_half = block.half_level[byte_offset[2:1]];
    assign sel_word = block.word_level[byte_offset[2]];

    // lb, lh, lw sign extend; lbu, lhu, lwu do not
    assign sign_ext = !funct3[2];

    always_comb begin
        case (mem_size_t'(funct3[1:0]))
            BYTE: begin
                result = {{56{sign_ext & sel_byte[7]}}, sel_byte};
            end
            HALF: begin
                result = {{48{sign_ext & sel_half[15]}}, sel_half};
            end
            WORD: begin
                result = {{32{sign_ext & sel_word[31]}}, sel_word};
            end
            default: begin
                result = block.dbbl_level;
            end
        endcase
    end

endmodule

// File: load_fu/load_fu.sv
`timescale 1ns/1ps

module load_fu (
    input  logic                           clock,
    input  logic                           reset,

    input  logic                           issue_valid,
    input  load_types_pkg::issue_packet_t  issue_pack,

    input  core_params_pkg::br_task_t      rem_br_task,
    input  core_params_pkg::br_mask_t      rem_b_id,

    input  logic                           mem_stall,
    input  logic                           store_en,

    input  logic                           resp_valid,
    input  load_types_pkg::addr_t          resp_addr,
    input  load_types_pkg::mem_block_t     resp_block,

    input  logic                           cdb_stall,

    output logic                           full,

    output logic                           start_load,
    output load_types_pkg::addr_t          mem_addr,

    output logic                           cdb_valid,
    output load_types_pkg::fu_packet_t     cdb_pack
);

    import core_params_pkg::*;
    import load_types_pkg::*;

    fu_packet_t [LD_DEPTH-1:0] entries, next_entries;
    logic [LD_DEPTH-1:0] open_spots, next_open_spots;
    logic [LD_DEPTH-1:0] ready_spots, next_ready_spots;
    logic [LD_DEPTH-1:0] data_ready_spots, next_data_ready_spots;

    // Entry that was stalled on the bus last cycle keeps the bus
    logic [LD_DEPTH-1:0] cdb_hold, next_cdb_hold;

    logic [LD_DEPTH-1:0] waiting_spots;
    logic [LD_DEPTH-1:0] kill_spots;
    logic [LD_DEPTH-1:0] alloc_gnt, issue_req, issue_gnt, cdb_req, cdb_gnt;
    data_t [LD_DEPTH-1:0] aligned;
    addr_t eff_addr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address generation and entry selection
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign eff_addr = issue_pack.base
                    + {{($bits(addr_t) - 12){issue_pack.offset[11]}}, issue_pack.offset};

    // Occupied entries that a squash this cycle takes away
    always_comb begin
        for (int i = 0; i < LD_DEPTH; i++) begin
            kill_spots[i] = (rem_br_task == SQUASH) && !open_spots[i]
                          && ((entries[i].b_mask & rem_b_id) != '0);
        end
    end

    assign waiting_spots = ~open_spots & ~ready_spots & ~data_ready_spots;

    assign issue_req = ready_spots & ~kill_spots;
    assign cdb_req   = ((cdb_hold & data_ready_spots) != '0) ? cdb_hold & ~kill_spots
                                                             : data_ready_spots & ~kill_spots;

    priority_select #(.WIDTH(LD_DEPTH)) alloc_sel (
        .req (open_spots),
        .gnt (alloc_gnt)
    );

    priority_select #(.WIDTH(LD_DEPTH)) issue_sel (
        .req (issue_req),
        .gnt (issue_gnt)
    );

    priority_select #(.WIDTH(LD_DEPTH)) cdb_sel (
        .req (cdb_req),
        .gnt (cdb_gnt)
    );

    for (genvar g = 0; g < LD_DEPTH; g++) begin : g_align
        load_align align (
            .funct3      (entries[g].funct3),
            .byte_offset (entries[g].target_addr[2:0]),
            .block       (resp_block),
            .result      (aligned[g])
        );
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Next state, in priority order per entry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        next_entries = entries;
        next_open_spots = open_spots;
        next_ready_spots = ready_spots;
        next_data_ready_spots = data_ready_spots;
        start_load = 1'b0;
        mem_addr = '0;
        cdb_valid = 1'b0;
        cdb_pack = '0;

        for (int i = 0; i < LD_DEPTH; i++) begin
            if (issue_valid && alloc_gnt[i]) begin
                next_entries[i].dest_tag = issue_pack.dest_tag;
                next_entries[i].b_mask = issue_pack.b_mask;
                next_entries[i].funct3 = issue_pack.funct3;
                next_entries[i].target_addr = eff_addr;
                next_entries[i].result = '0;
                next_open_spots[i] = 1'b0;
                // x0 never needs memory and is done right away
                if (issue_pack.dest_tag == '0) begin
                    next_entries[i].state = DATA_READY;
                    next_ready_spots[i] = 1'b0;
                    next_data_ready_spots[i] = 1'b1;
                end else begin
                    next_entries[i].state = READY_TO_ISSUE;
                    next_ready_spots[i] = 1'b1;
                    next_data_ready_spots[i] = 1'b0;
                end
            end

            if (!next_open_spots[i] && ((next_entries[i].b_mask & rem_b_id) != '0)) begin
                if (rem_br_task == SQUASH) begin
                    next_open_spots[i] = 1'b1;
                    next_ready_spots[i] = 1'b0;
                    next_data_ready_spots[i] = 1'b0;
                end else if (rem_br_task == CLEAR) begin
                    next_entries[i].b_mask = next_entries[i].b_mask & ~rem_b_id;
                end
            end

            if (issue_gnt[i] && !mem_stall && !store_en) begin
                start_load = 1'b1;
                mem_addr = {next_entries[i].target_addr[15:3], 3'b000};
                next_entries[i].state = WAITING_FOR_DATA;
                next_ready_spots[i] = 1'b0;
            end

            if (resp_valid && waiting_spots[i] && !kill_spots[i]
                    && resp_addr[15:3] == entries[i].target_addr[15:3]) begin
                next_entries[i].result = aligned[i];
                next_entries[i].state = DATA_READY;
                next_data_ready_spots[i] = 1'b1;
            end

            if (cdb_gnt[i]) begin
                cdb_valid = 1'b1;
                cdb_pack = next_entries[i];
                if (!cdb_stall) begin
                    next_open_spots[i] = 1'b1;
                    next_data_ready_spots[i] = 1'b0;
                end
            end
        end
    end

    assign next_cdb_hold = (cdb_valid && cdb_stall) ? cdb_gnt : '0;
    assign full = (next_open_spots == '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            open_spots <= '1;
            ready_spots <= '0;
            data_ready_spots <= '0;
            cdb_hold <= '0;
        end else begin
            open_spots <= next_open_spots;
            ready_spots <= next_ready_spots;
            data_ready_spots <= next_data_ready_spots;
            cdb_hold <= next_cdb_hold;
        end
    end

    always_ff @(posedge clock) begin
        entries <= next_entries;
    end

endmodule

// File: verilog/data_memory.sv
`timescale 1ns/1ps

module data_memory (
    input  logic                        clock,
    input  logic                        reset,

    input  logic                        store_en,
    input  load_types_pkg::addr_t       store_addr,
    input  load_types_pkg::mem_block_t  store_data,

    input  logic                        start_load,
    input  load_types_pkg::addr_t       mem_addr,

    output logic                        resp_valid,
    output load_types_pkg::addr_t       resp_addr,
    output load_types_pkg::mem_block_t  resp_block
);

    import core_params_pkg::*;
    import load_types_pkg::*;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } mem_req_t;

    mem_block_t mem [MEM_BLOCKS];
    mem_req_t [MEM_LATENCY-1:0] req_pipe;

    logic [$clog2(MEM_BLOCKS)-1:0] store_idx;
    logic [$clog2(MEM_BLOCKS)-1:0] read_idx;

    // Block index sits just above the byte-in-block bits
    assign store_idx = store_addr[3 +: $clog2(MEM_BLOCKS)];
    assign read_idx  = req_pipe[MEM_LATENCY-1].addr[3 +: $clog2(MEM_BLOCKS)];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Block storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < MEM_BLOCKS; i++) begin
                mem[i] <= '0;
            end
        end else if (store_en) begin
            mem[store_idx] <= store_data;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read pipeline
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clock) begin
        req_pipe[0].addr <= mem_addr;
        for (int s = 1; s < MEM_LATENCY; s++) begin
            req_pipe[s].addr <= req_pipe[s-1].addr;
        end
        if (reset) begin
            for (int s = 0; s < MEM_LATENCY; s++) begin
                req_pipe[s].valid <= 1'b0;
            end
        end else begin
            req_pipe[0].valid <= start_load;
            for (int s = 1; s < MEM_LATENCY; s++) begin
                req_pipe[s].valid <= req_pipe[s-1].valid;
            end
        end
    end

    // Reading at the last stage lets stores made in flight show up
    assign resp_valid = req_pipe[MEM_LATENCY-1].valid;
    assign resp_addr  = req_pipe[MEM_LATENCY-1].addr;
    assign resp_block = mem[read_idx];

endmodule

// File: verilog/load_unit_top.sv
`timescale 1ns/1ps

module load_unit_top (
    input  logic                           clock,
    input  logic                           reset,

    input  logic                           issue_valid,
    input  load_types_pkg::issue_packet_t  issue_pack,

    input  core_params_pkg::br_task_t      rem_br_task,
    input  core_params_pkg::br_mask_t      rem_b_id,

    input  logic                           mem_stall,

    input  logic                           store_en,
    input  load_types_pkg::addr_t          store_addr,
    input  load_types_pkg::mem_block_t     store_data,

    input  logic                           cdb_stall,

    output logic                           full,
    output logic                           cdb_valid,
    output load_types_pkg::fu_packet_t     cdb_pack
);

    import load_types_pkg::*;

    logic       start_load;
    addr_t      mem_addr;
    logic       resp_valid;
    addr_t      resp_addr;
    mem_block_t resp_block;

    load_fu fu (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_pack  (issue_pack),
        .rem_br_task (rem_br_task),
        .rem_b_id    (rem_b_id),
        .mem_stall   (mem_stall),
        .store_en    (store_en),
        .resp_valid  (resp_valid),
        .resp_addr   (resp_addr),
        .resp_block  (resp_block),
        .cdb_stall   (cdb_stall),
        .full        (full),
        .start_load  (start_load),
        .mem_addr    (mem_addr),
        .cdb_valid   (cdb_valid),
        .cdb_pack    (cdb_pack)
    );

    data_memory dmem (
        .clock      (clock),
        .reset      (reset),
        .store_en   (store_en),
        .store_addr (store_addr),
        .store_data (store_data),
        .start_load (start_load),
        .mem_addr   (mem_addr),
        .resp_valid (resp_valid),
        .resp_addr  (resp_addr),
        .resp_block (resp_block)
    );

endmodule

// File: tests/load_cases.svh
`ifndef LOAD_CASES_SVH
`define LOAD_CASES_SVH

typedef enum logic [2:0] {
    OP_STORE,
    OP_LOAD,
    OP_SQUASH,
    OP_CLEAR,
    OP_STALL_CDB,
    OP_STALL_MEM,
    OP_WAIT
} op_t;

// With fix set a store writes the data column and a load expects the exp column,
// otherwise the store writes random data and the load is checked against the mirror
typedef struct packed {
    op_t         op;
    addr_t       addr;
    logic [11:0] offset;
    logic [2:0]  funct3;
    logic [5:0]  tag;
    br_mask_t    mask;
    data_t       data;
    data_t       exp;
    logic        fix;
    logic [63:0] name;
} case_t;

localparam int N_CASES = 47;

// op, address, offset, funct3, tag, mask, data (store value, stall level or wait
// cycles, zero waits until nothing is pending), expected result, fix, name
localparam case_t CASES [N_CASES] = '{
    '{OP_STORE, 16'd8, 12'sd0, 3'd0, 6'd0, 4'h0, 64'd0, 64'd0, 1'b0, "pre_blk1"},
    '{OP_STORE, 16'd16, 12'sd0, 3'd0, 6'd0, 4'h0, 64'd0, 64'd0, 1'b0, "pre_blk2"},
    '{OP_STORE, 16'd24, 12'sd0, 3'd0, 6'd0, 4'h0, 64'd0, 64'd0, 1'b0, "pre_blk3"},
    '{OP_LOAD, 16'd8, 12'sd3, 3'd0, 6'd1, 4'h0, 64'd0, 64'd0, 1'b0, "lb_off_3"},
    '{OP_LOAD, 16'd8, 12'sd7, 3'd4, 6'd2, 4'h0, 64'd0, 64'd0, 1'b0, "lbu_of_7"},
    '{OP_LOAD, 16'd16, 12'sd2, 3'd1, 6'd3, 4'h0, 64'd0, 64'd0, 1'b0, "lh_off_2"},
    '{OP_LOAD, 16'd24, -12'sd2, 3'd5, 6'd4, 4'h0, 64'd0, 64'd0, 1'b0, "lhu_of_6"},
    '{OP_LOAD, 16'd16, 12'sd4, 3'd2, 6'd5, 4'h0, 64'd0, 64'd0, 1'b0, "lw_off_4"},
    '{OP_LOAD, 16'd8, 12'sd0, 3'd6, 6'd6, 4'h0, 64'd0, 64'd0, 1'b0, "lwu_of_0"},
    '{OP_LOAD, 16'd32, -12'sd8, 3'd3, 6'd7, 4'h0, 64'd0, 64'd0, 1'b0, "ld_off_0"},
    '{OP_LOAD, 16'd24, 12'sd5, 3'd0, 6'd8, 4'h0, 64'd0, 64'd0, 1'b0, "lb_off_5"},
    '{OP_WAIT, 16'd0, 12'sd0, 3'd0, 6'd0, 4'h0, 64'd0, 64'd0, 1'b0, "drain_01"},
    '{OP_LOAD, 16'd16, 12'sd0, 3'd3, 6'd0, 4'h0, 64'd0, 64'd0, 1'b1, "x0_load_"},
    '{OP_STORE, 16'd16, 12'sd0, 3'd0, 6'd0, 4'h0, 64'd0, 64'd0, 1'b0, "new_blk2"},
    '{OP_LOAD, 16'd16, 12'sd1, 3'd4, 6'd9, 4'h0, 64'd0, 64'd0, 1'b0, "lbu_new1"},
    '{OP_WAIT, 16'd0, 12'sd0, 3'd0, 6'd0, 4'h0, 64'd0, 64'd0, 1'b0, "drain_02"},
    '{OP_STALL_CDB, 16'd0, 12'sd0, 3'd0, 6'd0, 4'h0, 64'd1, 64'd0, 1'b0, "cdb_stl1"},
    '{OP_LOAD, 16'd8, 12'sd6, 3'd1, 6'd10, 4'h0, 64'd0, 64'd0, 1'b0, "lh_stl_6"},
    '{OP_LOAD, 16'd24, 12'sd0, 3'd2, 6'd11, 4'h0, 64'd0, 64'd0, 1'b0, "lw_stl_0"},
    '{OP_LOAD, 16'd24, 12'sd3, 3'd4, 6'd12, 4'h0, 64'd0, 64'd0, 1'b0, "lbu_stl3"},
    '{OP_WAIT, 16'd0, 12'sd0, 3'd0, 6'd0, 4'h0, 64'd12, 64'd0, 1'b0, "hold_bus"},
    '{OP_STALL_CDB, 16'd0, 12'sd0, 3'd0, 6'd0, 4'h0, 64'd0, 64'd0, 1'b0, "cdb_stl0"},
    '{OP_WAIT, 16'd0, 12'sd0, 3'd0, 6'd0, 4'h0, 64'd0, 64'd0, 1'b0, "drain_03"},
    '{OP_STALL_MEM, 16'd0, 12'sd0, 3'd0, 6'd0, 4'h0, 64'd1, 64'd0, 1'b0, "mem_stl1"},
    '{OP_LOAD, 16'd8, 12'sd1, 3'd0, 6'd13, 4'h1, 64'd0, 64'd0, 1'b0, "sq_tag13"},
    '{OP_LOAD, 16'd16, 12'sd6, 3'd5, 6'd14, 4'h2, 64'd0, 64'd0, 1'b0, "kp_tag14"},
    '{OP_LOAD, 16'd24, 12'sd2, 3'd1, 6'd15, 4'h3, 64'd0, 64'd0, 1'b0, "sq_tag15"},
    '{OP_LOAD, 16'd8, 12'sd4, 3'd6, 6'd16, 4'h4, 64'd0, 64'd0, 1'b0, "cl_tag16"},
    '{OP_SQUASH, 16'd0, 12'sd0, 3'd0, 6'd0, 4'h1, 64'd0, 64'd0, 1'b0, "squash_1"},
    '{OP_CLEAR, 16'd0, 12'sd0, 3'd0, 6'd0, 4'h4, 64'd0, 64'd0, 1'b0, "clear_4_"},
    '{OP_STALL_MEM, 16'd0, 12'sd0, 3'd0, 6'd0, 4'h0, 64'd0, 64'd0, 1'b0, "mem_stl0"},
    '{OP_WAIT, 16'd0, 12'sd0, 3'd0, 6'd0, 4'h0, 64'd0, 64'd0, 1'b0, "drain_04"},
    '{OP_STALL_MEM, 16'd0, 12'sd0, 3'd0, 6'd0, 4'h0, 64'd1, 64'd0, 1'b0, "mem_stl1"},
    '{OP_LOAD, 16'd8, 12'sd2, 3'd5, 6'd17, 4'h0, 64'd0, 64'd0, 1'b0, "ms_lhu_2"},
    '{OP_LOAD, 16'd16, 12'sd7, 3'd0, 6'd18, 4'h0, 64'd0, 64'd0, 1'b0, "ms_lb_7_"},
    '{OP_LOAD, 16'd24, 12'sd4, 3'd6, 6'd19, 4'h0, 64'd0, 64'd0, 1'b0, "ms_lwu_4"},
    '{OP_LOAD, 16'd16, -12'sd8, 3'd3, 6'd20, 4'h0, 64'd0, 64'd0, 1'b0, "ms_ld_8_"},
    '{OP_STALL_MEM, 16'd0, 12'sd0, 3'd0, 6'd0, 4'h0, 64'd0, 64'd0, 1'b0, "mem_stl0"},
    '{OP_WAIT, 16'd0, 12'sd0, 3'd0, 6'd0, 4'h0, 64'd0, 64'd0, 1'b0, "drain_05"},
    '{OP_LOAD, 16'd40, 12'sd6, 3'd1, 6'd21, 4'h0, 64'd0, 64'hFFFFFFFFFFFFF0E1, 1'b1, "st_lh_6_"},
    '{OP_STORE, 16'd40, 12'sd0, 3'd0, 6'd0, 4'h0, 64'h0123456789ABCDEF, 64'd0, 1'b1, "st_hold1"},
    '{OP_STORE, 16'd40, 12'sd0, 3'd0, 6'd0, 4'h0, 64'h0123456789ABCDEF, 64'd0, 1'b1, "st_hold2"},
    '{OP_STORE, 16'd40, 12'sd0, 3'd0, 6'd0, 4'h0, 64'h0123456789ABCDEF, 64'd0, 1'b1, "st_hold3"},
    '{OP_STORE, 16'd40, 12'sd0, 3'd0, 6'd0, 4'h0, 64'hF0E1D2C3B4A59687, 64'd0, 1'b1, "st_hold4"},
    '{OP_LOAD, 16'd40, 12'sd1, 3'd4, 6'd22, 4'h0, 64'd0, 64'h0000000000000096, 1'b1, "st_lbu_1"},
    '{OP_LOAD, 16'd44, 12'sd0, 3'd2, 6'd23, 4'h0, 64'd0, 64'hFFFFFFFFF0E1D2C3, 1'b1, "st_lw_4_"},
    '{OP_WAIT, 16'd0, 12'sd0, 3'd0, 6'd0, 4'h0, 64'd0, 64'd0, 1'b0, "drain_06"}
};

`endif

// File: tests/load_unit_tb.sv
`timescale 1ns/1ps

module load_unit_tb;

    import core_params_pkg::*;
    import load_types_pkg::*;

    `include "load_cases.svh"

    localparam int N_TAGS = 2 ** TAG_WIDTH;
    localparam int CYCLE_LIMIT = 20 * N_CASES + 100;

    logic          clock = 1'b0;
    logic          reset;
    logic          issue_valid;
    issue_packet_t issue_pack;
    br_task_t      rem_br_task;
    br_mask_t      rem_b_id;
    logic          mem_stall;
    logic          store_en;
    addr_t         store_addr;
    mem_block_t    store_data;
    logic          cdb_stall;
    logic          full;
    logic          cdb_valid;
    fu_packet_t    cdb_pack;

    int         seed;
    int         errors;
    int         broadcasts;
    int         cycles;
    logic       full_seen;
    logic       full_hit;
    logic       held_valid;
    fu_packet_t held_pack;
    data_t      mirror [MEM_BLOCKS];

    // Scoreboard of loads in flight, indexed by destination tag
    logic        pend_active [N_TAGS];
    logic        pend_squashed [N_TAGS];
    logic        pend_fix [N_TAGS];
    addr_t       pend_addr [N_TAGS];
    logic [2:0]  pend_f3 [N_TAGS];
    br_mask_t    pend_mask [N_TAGS];
    data_t       pend_exp [N_TAGS];
    logic [63:0] pend_name [N_TAGS];

    load_unit_top uut (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_pack  (issue_pack),
        .rem_br_task (rem_br_task),
        .rem_b_id    (rem_b_id),
        .mem_stall   (mem_stall),
        .store_en    (store_en),
        .store_addr  (store_addr),
        .store_data  (store_data),
        .cdb_stall   (cdb_stall),
        .full        (full),
        .cdb_valid   (cdb_valid),
        .cdb_pack    (cdb_pack)
    );

    always #2 clock = ~clock;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic data_t aligned_value(data_t blk, logic [2:0] f3, logic [2:0] off);
        int    nbytes;
        int    lo;
        data_t keep;
        data_t v;
        nbytes = 1 << f3[1:0];
        lo = int'(off) & ~(nbytes - 1);
        keep = (nbytes == 8) ? '1 : ((64'd1 << (8 * nbytes)) - 64'd1);
        v = (blk >> (8 * lo)) & keep;
        // Signed loads copy the top bit of the picked field upward
        if (!f3[2] && nbytes < 8 && v[8 * nbytes - 1])
            v = v | ~keep;
        return v;
    endfunction

    function automatic data_t result_for(logic [TAG_WIDTH-1:0] t);
        data_t v;
        if (pend_fix[t])
            v = pend_exp[t];
        else if (t == '0)
            v = '0;
        else
            v = aligned_value(mirror[pend_addr[t][7:3]], pend_f3[t], pend_addr[t][2:0]);
        return v;
    endfunction

    function automatic int pending_count();
        int n;
        n = 0;
        for (int t = 0; t < N_TAGS; t++) begin
            if (pend_active[t])
                n++;
        end
        return n;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Driver
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic apply_row(input case_t c);
        data_t blk;
        addr_t ea;
        @(posedge clock);
        #1;
        issue_valid = 1'b0;
        rem_br_task = NONE;
        rem_b_id = '0;
        store_en = 1'b0;
        case (c.op)
            OP_STORE: begin
                blk = c.fix ? c.data : {$random(seed), $random(seed)};
                store_en = 1'b1;
                store_addr = c.addr;
                store_data = blk;
                mirror[c.addr[7:3]] = blk;
            end
            OP_LOAD: begin
                // full tells whether the coming cycle still has an open entry
                while (full_seen) begin
                    @(posedge clock);
                    #1;
                end
                ea = c.addr + {{4{c.offset[11]}}, c.offset};
                issue_valid = 1'b1;
                issue_pack.base = c.addr;
                issue_pack.offset = c.offset;
                issue_pack.funct3 = c.funct3;
                issue_pack.dest_tag = c.tag;
                issue_pack.b_mask = c.mask;
                pend_active[c.tag] = 1'b1;
                pend_squashed[c.tag] = 1'b0;
                pend_fix[c.tag] = c.fix;
                pend_addr[c.tag] = ea;
                pend_f3[c.tag] = c.funct3;
                pend_mask[c.tag] = c.mask;
                pend_exp[c.tag] = c.exp;
                pend_name[c.tag] = c.name;
            end
            OP_SQUASH: begin
                rem_br_task = SQUASH;
                rem_b_id = c.mask;
                for (int t = 0; t < N_TAGS; t++) begin
                    if (pend_active[t] && (pend_mask[t] & c.mask) != '0) begin
                        pend_active[t] = 1'b0;
                        pend_squashed[t] = 1'b1;
                    end
                end
            end
            OP_CLEAR: begin
                rem_br_task = CLEAR;
                rem_b_id = c.mask;
                for (int t = 0; t < N_TAGS; t++) begin
                    if (pend_active[t])
                        pend_mask[t] = pend_mask[t] & ~c.mask;
                end
            end
            OP_STALL_CDB: cdb_stall = c.data[0];
            OP_STALL_MEM: mem_stall = c.data[0];
            OP_WAIT: begin
                if (c.data == '0) begin
                    while (pending_count() != 0)
                        @(posedge clock);
                end else begin
                    repeat (c.data[7:0] - 8'd1) @(posedge clock);
                end
            end
            default: begin
            end
        endcase
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus monitor and timeout
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic watch_bus();
        logic [TAG_WIDTH-1:0] t;
        data_t                want;
        forever begin
            @(negedge clock);
            if (!reset) begin
                full_seen = full;
                if (full)
                    full_hit = 1'b1;
                if (held_valid) begin
                    assert (cdb_valid && cdb_pack == held_pack) else begin
                        $display("Bus packet changed while the bus was stalled");
                        errors++;
                    end
                end
                held_valid = cdb_valid && cdb_stall;
                held_pack = cdb_pack;
                if (cdb_valid && !cdb_stall) begin
                    t = cdb_pack.dest_tag;
                    broadcasts++;
                    assert (pend_active[t]) else begin
                        if (pend_squashed[t])
                            $display("Tag %0d was broadcast after it was squashed", t);
                        else
                            $display("Tag %0d was broadcast but no such load is pending", t);
                        errors++;
                    end
                    if (pend_active[t]) begin
                        want = result_for(t);
                        assert (cdb_pack.result == want) else begin
                            $display("FAILED %s: expected %h, actual %h",
                                     pend_name[t], want, cdb_pack.result);
                            errors++;
                        end
                        assert (cdb_pack.b_mask == pend_mask[t]) else begin
                            $display("FAILED %s b_mask: expected %b, actual %b",
                                     pend_name[t], pend_mask[t], cdb_pack.b_mask);
                            errors++;
                        end
                        assert (cdb_pack.target_addr == pend_addr[t]) else begin
                            $display("FAILED %s address: expected %h, actual %h",
                                     pend_name[t], pend_addr[t], cdb_pack.target_addr);
                            errors++;
                        end
                        assert (cdb_pack.funct3 == pend_f3[t]) else begin
                            $display("FAILED %s funct3: expected %0d, actual %0d",
                                     pend_name[t], pend_f3[t], cdb_pack.funct3);
                            errors++;
                        end
                        assert (cdb_pack.state == DATA_READY) else begin
                            $display("FAILED %s state: expected %0d, actual %0d",
                                     pend_name[t], DATA_READY, cdb_pack.state);
                            errors++;
                        end
                        pend_active[t] = 1'b0;
                    end
                end
            end
        end
    endtask

    task automatic enforce_timeout();
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clock);
            cycles++;
        end
        for (int t = 0; t < N_TAGS; t++) begin
            if (pend_active[t])
                $display("Tag %0d (%s) was never broadcast", t, pend_name[t]);
        end
        $display("Timeout after %0d cycles, %0d errors", cycles, errors);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    initial begin
        reset = 1'b1;
        issue_valid = 1'b0;
        issue_pack = '0;
        rem_br_task = NONE;
        rem_b_id = '0;
        mem_stall = 1'b0;
        store_en = 1'b0;
        store_addr = '0;
        store_data = '0;
        cdb_stall = 1'b0;
        seed = 55;
        errors = 0;
        broadcasts = 0;
        cycles = 0;
        full_seen = 1'b0;
        full_hit = 1'b0;
        held_valid = 1'b0;
        held_pack = '0;
        for (int t = 0; t < N_TAGS; t++) begin
            pend_active[t] = 1'b0;
            pend_squashed[t] = 1'b0;
            pend_name[t] = '0;
        end
        for (int b = 0; b < MEM_BLOCKS; b++) begin
            mirror[b] = '0;
        end

        fork
            watch_bus();
            enforce_timeout();
        join_none

        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;

        for (int r = 0; r < N_CASES; r++) begin
            apply_row(CASES[r]);
        end
        while (pending_count() != 0)
            @(posedge clock);
        @(posedge clock);

        assert (full_hit) else begin
            $display("full never rose while loads were held back");
            errors++;
        end
        $display("Checked %0d broadcasts, %0d errors", broadcasts, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+tests
common/core_params_pkg.sv
common/load_types_pkg.sv
verilog/priority_select.sv
load_fu/load_align.sv
load_fu/load_fu.sv
verilog/data_memory.sv
verilog/load_unit_top.sv
tests/load_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the load unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module load_unit_tb -f verilog.f -Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vload_unit_tb)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
else
    exit 1
fi
